//--- bench/fabric_asserts.sv
`timescale 1ns/1ps

module fabric_asserts import fabric_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       awready,
	input logic       wready,
	input logic       arready,
	input logic       bvalid,
	input logic       bready,
	input axil_resp_t bresp,
	input logic       rvalid,
	input logic       rready,
	input axil_resp_t rresp,
	input cfg_data_t  rdata,
	input logic       cfg_we
);

	int unsigned fail_count = 0; // Failed checks so far.

	reset_ready_low: assert property (@(posedge clk) rst |-> !awready && !wready && !arready)
		else begin
			$error("A ready output was high during reset.");
			fail_count++;
		end

	// Registered control outputs must be cleared by the reset edge.
	reset_outputs_low: assert property (@(posedge clk) rst |=> !bvalid && !rvalid && !cfg_we)
		else begin
			$error("bvalid, rvalid or cfg_we was high right after reset.");
			fail_count++;
		end

	bvalid_held: assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready.");
			fail_count++;
		end

	rvalid_held: assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready.");
			fail_count++;
		end

	bresp_okay: assert property (@(posedge clk) disable iff (rst) bvalid |-> bresp == RESP_OKAY)
		else begin
			$error("Write response was not OKAY.");
			fail_count++;
		end

	read_error: assert property (@(posedge clk) disable iff (rst)
		rvalid |-> rresp == RESP_SLVERR && rdata == '0)
		else begin
			$error("Read response was not SLVERR with zero data.");
			fail_count++;
		end

	no_accept_pending: assert property (@(posedge clk) disable iff (rst) bvalid |-> !awready)
		else begin
			$error("A write was accepted while a response was pending.");
			fail_count++;
		end

endmodule

bind fabric_top fabric_asserts u_asserts (
	.clk     (clk),
	.rst     (rst),
	.awready (awready),
	.wready  (wready),
	.arready (arready),
	.bvalid  (bvalid),
	.bready  (bready),
	.bresp   (bresp),
	.rvalid  (rvalid),
	.rready  (rready),
	.rresp   (rresp),
	.rdata   (rdata),
	.cfg_we  (cfg_we)
);

//--- bench/tb_fabric.sv
`timescale 1ns/1ps

module tb_fabric import fabric_pkg::*; ();

	localparam tile_id_t TILE_ID = 16'd3;
	localparam int TIMEOUT = 50; // Cycles allowed for any handshake.

	logic clk;
	logic rst;
	cfg_addr_t awaddr;
	logic awvalid;
	logic awready;
	cfg_data_t wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	axil_resp_t bresp;
	logic bvalid;
	logic bready;
	cfg_addr_t araddr;
	logic arvalid;
	logic arready;
	cfg_data_t rdata;
	axil_resp_t rresp;
	logic rvalid;
	logic rready;
	track_t track_in_0;
	track_t track_in_1;
	track_t track_in_2;
	track_t track_in_3;
	track_t track_out_0;
	track_t track_out_1;
	track_t track_out_2;
	track_t track_out_3;

	integer seed = 32'h8343_e93f;
	cfg_data_t model_sb;
	int model_cb0;
	int model_cb1;
	int model_op; // 0 AND, 1 OR, 2 XOR, 3 NAND.
	logic model_pe;

	fabric_top #(.TILE_ID(TILE_ID)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_failure();
		$display("=== FAIL ===");
		$fatal(1, "Stopped at the first failure.");
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			report_failure();
		end
	endtask

	// Field 0 routes pe_out, field n routes track t of side s+n.
	function automatic logic [15:0] route_tracks(cfg_data_t cfg, logic [15:0] ins, logic pe);
		logic [15:0] outs;
		logic [15:0] shifted;
		int field;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				field = int'((cfg >> (2 * (4 * s + t))) & 32'd3);
				shifted = ins >> (4 * ((s + field) % 4) + t);
				outs[4 * s + t] = (field == 0) ? pe : shifted[0];
			end
		end
		return outs;
	endfunction

	function automatic logic pick_operand(int sel, track_t in_t, track_t loop_t);
		logic [7:0] shifted;
		shifted = {loop_t, in_t} >> sel;
		return shifted[0];
	endfunction

	function automatic logic apply_function(int op, logic a, logic b);
		case (op)
			0: return a & b;
			1: return a | b;
			2: return a ^ b;
			default: return !(a & b);
		endcase
	endfunction

	task automatic check_tracks();
		logic [15:0] outs;
		outs = route_tracks(model_sb, {track_in_3, track_in_2, track_in_1, track_in_0}, model_pe);
		check_value("track_out_0", 32'(track_out_0), 32'(outs[3:0]));
		check_value("track_out_1", 32'(track_out_1), 32'(outs[7:4]));
		check_value("track_out_2", 32'(track_out_2), 32'(outs[11:8]));
		check_value("track_out_3", 32'(track_out_3), 32'(outs[15:12]));
	endtask

	// Two cycles with steady inputs let pe_out take up the new operands.
	task automatic settle_and_check();
		logic [15:0] outs;
		repeat (2) @(posedge clk);
		@(negedge clk);
		outs = route_tracks(model_sb, {track_in_3, track_in_2, track_in_1, track_in_0}, model_pe);
		model_pe = apply_function(model_op, pick_operand(model_cb0, track_in_0, outs[3:0]),
			pick_operand(model_cb1, track_in_1, outs[7:4]));
		check_tracks();
	endtask

	task automatic drive_random_inputs();
		logic [31:0] rnd;
		rnd = $random(seed);
		@(posedge clk);
		track_in_0 <= rnd[3:0];
		track_in_1 <= rnd[7:4];
		track_in_2 <= rnd[11:8];
		track_in_3 <= rnd[15:12];
	endtask

	function automatic logic is_high(string name);
		if (name == "awready") return awready && wready;
		if (name == "bvalid") return bvalid;
		if (name == "arready") return arready;
		return rvalid;
	endfunction

	task automatic wait_high(string name);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!is_high(name)) begin
			cycles++;
			if (cycles > TIMEOUT) begin
				$display("Timeout: %s stayed low for %0d cycles.", name, TIMEOUT);
				report_failure();
			end
			@(negedge clk);
		end
	endtask

	task automatic start_write(cfg_addr_t addr, cfg_data_t data);
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
	endtask

	task automatic finish_write();
		wait_high("awready");
		@(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		wait_high("bvalid");
		@(posedge clk);
	endtask

	task automatic axil_write(cfg_addr_t addr, cfg_data_t data);
		start_write(addr, data);
		finish_write();
	endtask

	task automatic axil_read(cfg_addr_t addr);
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		wait_high("arready");
		@(posedge clk);
		arvalid <= 1'b0;
		wait_high("rvalid");
		@(posedge clk);
	endtask

	initial begin
		logic [31:0] rnd;
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = 4'hf;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		track_in_0 = 4'hf; // High inputs show up on any output that does not route pe_out.
		track_in_1 = 4'hf;
		track_in_2 = 4'hf;
		track_in_3 = 4'hf;
		model_sb = '0;
		model_cb0 = 0;
		model_cb1 = 0;
		model_op = 0;
		model_pe = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_tracks();

		repeat (20) begin
			rnd = $random(seed);
			axil_write({BLK_SB, TILE_ID}, rnd);
			model_sb = rnd;
			drive_random_inputs();
			settle_and_check();
		end

		model_sb = 32'h1555_5555; // pe_out on side 3 track 3, neighbour inputs elsewhere.
		axil_write({BLK_SB, TILE_ID}, model_sb);
		for (int sel = 0; sel < 8; sel++) begin
			axil_write({BLK_CB0, TILE_ID}, 32'(sel));
			axil_write({BLK_CB1, TILE_ID}, 32'(7 - sel));
			model_cb0 = sel;
			model_cb1 = 7 - sel;
			for (int op = 0; op < 4; op++) begin
				axil_write({BLK_CLB, TILE_ID}, 32'(op));
				model_op = op;
				repeat (2) begin
					drive_random_inputs();
					settle_and_check();
				end
			end
		end
		axil_write({BLK_CB0, TILE_ID}, 32'd0);
		axil_write({BLK_CB1, TILE_ID}, 32'd1);
		model_cb0 = 0;
		model_cb1 = 1;
		settle_and_check();

		axil_write({BLK_SB, TILE_ID + 16'd1}, 32'hffff_ffff);
		axil_write({16'd9, TILE_ID}, 32'hffff_ffff);
		settle_and_check();

		@(posedge clk);
		bready <= 1'b0;
		rnd = $random(seed);
		axil_write({BLK_SB, TILE_ID}, rnd);
		rnd = $random(seed);
		start_write({BLK_SB, TILE_ID}, rnd);
		repeat (4) @(posedge clk); // The response stays pending, so nothing is accepted here.
		bready <= 1'b1;
		finish_write();
		model_sb = rnd;
		settle_and_check();

		@(posedge clk);
		rready <= 1'b0;
		rnd = $random(seed);
		axil_read(rnd);
		repeat (3) @(posedge clk); // The read response has to stay valid while rready is low.
		rready <= 1'b1;
		repeat (3) begin
			rnd = $random(seed);
			axil_read(rnd);
		end

		if (u_dut.u_asserts.fail_count == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("Protocol assertions failed %0d times.", u_dut.u_asserts.fail_count);
			report_failure();
		end
	end

endmodule

//--- fabric_tile.f
verilog/fabric_pkg.sv
verilog/config_axil_slave.sv
verilog/connect_box.sv
verilog/switch_box.sv
verilog/clb.sv
verilog/pe_tile.sv
verilog/fabric_top.sv
bench/fabric_asserts.sv
bench/tb_fabric.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_fabric -f fabric_tile.f -o sim_fabric \
	&& ./obj_dir/sim_fabric > sim.log 2>&1 \
	|| echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1
exit 0

//--- verilog/clb.sv
`timescale 1ns/1ps

module clb import fabric_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    cfg_en,
	input  clb_op_t cfg_data,
	input  logic    in0,
	input  logic    in1,
	output logic    out
);

	clb_op_t op;
	logic result;

	always_ff @(posedge clk) begin
		if (rst) begin
			op <= CLB_AND;
		end else if (cfg_en) begin
			op <= cfg_data;
		end
	end

	always_comb begin
		case (op)
			CLB_AND:  result = in0 & in1;
			CLB_OR:   result = in0 | in1;
			CLB_XOR:  result = in0 ^ in1;
			CLB_NAND: result = ~(in0 & in1);
			default:  result = 1'b0;
		endcase
	end

	// One cycle of latency from the operands to out.
	always_ff @(posedge clk) begin
		if (rst) begin
			out <= 1'b0;
		end else begin
			out <= result;
		end
	end

endmodule

//--- verilog/config_axil_slave.sv
`timescale 1ns/1ps

module config_axil_slave import fabric_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  cfg_addr_t  awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  cfg_data_t  wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output axil_resp_t bresp,
	output logic       bvalid,
	input  logic       bready,
	input  cfg_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output cfg_data_t  rdata,
	output axil_resp_t rresp,
	output logic       rvalid,
	input  logic       rready,
	output logic       cfg_we,
	output cfg_addr_t  cfg_addr,
	output cfg_data_t  cfg_data
);

	logic wr_accept;
	logic rd_accept;

	// Address and data are taken in the same cycle, and only with no response pending.
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;

	assign rd_accept = arvalid && !rvalid;
	assign arready = rd_accept;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_SLVERR; // The configuration space is write-only.
	assign rdata = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg_we <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			cfg_we <= wr_accept; // One-cycle pulse after the accept cycle.
			if (wr_accept) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// Configuration words are always written whole, so wstrb is not looked at.
	always_ff @(posedge clk) begin
		if (wr_accept) begin
			cfg_addr <= awaddr;
			cfg_data <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else begin
			if (rd_accept) begin
				rvalid <= 1'b1; // Every read gets an error whatever araddr holds.
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

endmodule

//--- verilog/connect_box.sv
`timescale 1ns/1ps

module connect_box import fabric_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    cfg_en,
	input  cb_sel_t cfg_data,
	input  track_t  track_in,
	input  track_t  track_loop,
	output logic    block_out
);

	cb_sel_t sel;
	logic [7:0] tracks;

	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
		end else if (cfg_en) begin
			sel <= cfg_data;
		end
	end

	// Selects 0 to 3 pick an input track, 4 to 7 a switch-box output track.
	assign tracks = {track_loop, track_in};

	assign block_out = tracks[sel];

endmodule

//--- verilog/fabric_pkg.sv
package fabric_pkg;

	typedef logic [3:0] track_t;
	typedef logic [31:0] cfg_addr_t;
	typedef logic [31:0] cfg_data_t;
	typedef logic [15:0] tile_id_t;

	typedef logic [2:0] cb_sel_t;
	typedef logic [1:0] sb_sel_t;

	typedef enum logic [1:0] {
		CLB_AND  = 2'd0,
		CLB_OR   = 2'd1,
		CLB_XOR  = 2'd2,
		CLB_NAND = 2'd3
	} clb_op_t;

	typedef logic [1:0] axil_resp_t;

	// Block numbers sit in the upper half of a configuration address.
	localparam logic [15:0] BLK_SB  = 16'd7;
	localparam logic [15:0] BLK_CB0 = 16'd6;
	localparam logic [15:0] BLK_CB1 = 16'd5;
	localparam logic [15:0] BLK_CLB = 16'd4;

	localparam axil_resp_t RESP_OKAY   = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

endpackage

//--- verilog/fabric_top.sv
`timescale 1ns/1ps

module fabric_top import fabric_pkg::*; #(
	parameter tile_id_t TILE_ID = 16'd3
) (
	input  logic       clk,
	input  logic       rst,
	input  cfg_addr_t  awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  cfg_data_t  wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output axil_resp_t bresp,
	output logic       bvalid,
	input  logic       bready,
	input  cfg_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output cfg_data_t  rdata,
	output axil_resp_t rresp,
	output logic       rvalid,
	input  logic       rready,
	input  track_t     track_in_0,
	input  track_t     track_in_1,
	input  track_t     track_in_2,
	input  track_t     track_in_3,
	output track_t     track_out_0,
	output track_t     track_out_1,
	output track_t     track_out_2,
	output track_t     track_out_3
);

	logic cfg_we;
	cfg_addr_t cfg_addr;
	cfg_data_t cfg_data;

	config_axil_slave u_cfg (
		.clk      (clk),
		.rst      (rst),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.cfg_we   (cfg_we),
		.cfg_addr (cfg_addr),
		.cfg_data (cfg_data)
	);

	pe_tile #(
		.TILE_ID (TILE_ID)
	) u_tile (
		.clk         (clk),
		.rst         (rst),
		.cfg_we      (cfg_we),
		.cfg_addr    (cfg_addr),
		.cfg_data    (cfg_data),
		.track_in_0  (track_in_0),
		.track_in_1  (track_in_1),
		.track_in_2  (track_in_2),
		.track_in_3  (track_in_3),
		.track_out_0 (track_out_0),
		.track_out_1 (track_out_1),
		.track_out_2 (track_out_2),
		.track_out_3 (track_out_3)
	);

endmodule

//--- verilog/pe_tile.sv
`timescale 1ns/1ps

module pe_tile import fabric_pkg::*; #(
	parameter tile_id_t TILE_ID = 16'd3
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      cfg_we,
	input  cfg_addr_t cfg_addr,
	input  cfg_data_t cfg_data,
	input  track_t    track_in_0,
	input  track_t    track_in_1,
	input  track_t    track_in_2,
	input  track_t    track_in_3,
	output track_t    track_out_0,
	output track_t    track_out_1,
	output track_t    track_out_2,
	output track_t    track_out_3
);

	logic tile_hit;
	logic en_sb;
	logic en_cb0;
	logic en_cb1;
	logic en_clb;
	logic op_0;
	logic op_1;
	logic pe_out;

	// Writes to another tile or an unknown block enable nothing.
	assign tile_hit = cfg_we && (cfg_addr[15:0] == TILE_ID);

	assign en_sb  = tile_hit && (cfg_addr[31:16] == BLK_SB);
	assign en_cb0 = tile_hit && (cfg_addr[31:16] == BLK_CB0);
	assign en_cb1 = tile_hit && (cfg_addr[31:16] == BLK_CB1);
	assign en_clb = tile_hit && (cfg_addr[31:16] == BLK_CLB);

	connect_box cb0 (
		.clk        (clk),
		.rst        (rst),
		.cfg_en     (en_cb0),
		.cfg_data   (cb_sel_t'(cfg_data[2:0])),
		.track_in   (track_in_0),
		.track_loop (track_out_0),
		.block_out  (op_0)
	);

	connect_box cb1 (
		.clk        (clk),
		.rst        (rst),
		.cfg_en     (en_cb1),
		.cfg_data   (cb_sel_t'(cfg_data[2:0])),
		.track_in   (track_in_1),
		.track_loop (track_out_1),
		.block_out  (op_1)
	);

	switch_box sb (
		.clk         (clk),
		.rst         (rst),
		.cfg_en      (en_sb),
		.cfg_data    (cfg_data),
		.track_in_0  (track_in_0),
		.track_in_1  (track_in_1),
		.track_in_2  (track_in_2),
		.track_in_3  (track_in_3),
		.pe_out      (pe_out),
		.track_out_0 (track_out_0),
		.track_out_1 (track_out_1),
		.track_out_2 (track_out_2),
		.track_out_3 (track_out_3)
	);

	// The registered output here breaks the loop through the switch box.
	clb compute_block (
		.clk      (clk),
		.rst      (rst),
		.cfg_en   (en_clb),
		.cfg_data (clb_op_t'(cfg_data[1:0])),
		.in0      (op_0),
		.in1      (op_1),
		.out      (pe_out)
	);

endmodule

//--- verilog/switch_box.sv
`timescale 1ns/1ps

module switch_box import fabric_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      cfg_en,
	input  cfg_data_t cfg_data,
	input  track_t    track_in_0,
	input  track_t    track_in_1,
	input  track_t    track_in_2,
	input  track_t    track_in_3,
	input  logic      pe_out,
	output track_t    track_out_0,
	output track_t    track_out_1,
	output track_t    track_out_2,
	output track_t    track_out_3
);

	cfg_data_t cfg;
	track_t in_side [4];
	track_t out_side [4];

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg <= '0; // Every output routes pe_out.
		end else if (cfg_en) begin
			cfg <= cfg_data;
		end
	end

	assign in_side[0] = track_in_0;
	assign in_side[1] = track_in_1;
	assign in_side[2] = track_in_2;
	assign in_side[3] = track_in_3;

	for (genvar s = 0; s < 4; s++) begin : g_side
		for (genvar t = 0; t < 4; t++) begin : g_track
			sb_sel_t sel;
			logic [3:0] src;

			// Field of output side s, track t.
			assign sel = cfg[(4 * s + t) * 2 +: 2];

			// Sources count sides onward from s, wrapping at four.
			assign src = {
				in_side[(s + 3) % 4][t],
				in_side[(s + 2) % 4][t],
				in_side[(s + 1) % 4][t],
				pe_out
			};

			assign out_side[s][t] = src[sel];
		end
	end

	assign track_out_0 = out_side[0];
	assign track_out_1 = out_side[1];
	assign track_out_2 = out_side[2];
	assign track_out_3 = out_side[3];

endmodule
